//--- filelist.f
rtl/cmd_pkg.sv
rtl/serial_pkg.sv
rtl/reset_ctrl.sv
rtl/uart_rx.sv
rtl/byte_fifo.sv
rtl/cmd_exec.sv
rtl/uart_tx.sv
rtl/led_top.sv
testbench/led_top_properties.sv
testbench/tb_led_top.sv

//--- testbench/tb_led_top.sv
`timescale 1ns/1ps

module tb_led_top
    import cmd_pkg::*;
;

    localparam int BIT_CLKS    = 16;            // pll_clk cycles per serial bit
    localparam int LOCK_CNT    = 15;
    localparam int N_FRAMES    = 57;            // 40 + 8 + 1 + 1 + 1 + 6
    localparam int CYCLE_LIMIT = N_FRAMES * 10 * BIT_CLKS * 2 + 2000;
    localparam int ECHO_WAIT   = 30 * BIT_CLKS; // gap allowed before an echo start bit

    logic             pll_clk;
    logic             rst_i;
    logic             pll_locked_i;
    logic             uart_rx_i;
    logic [LED_W-1:0] leds_o;
    logic             uart_tx_o;

    integer           seed;
    int               cycle_cnt;
    int               err_cnt;
    int               check_cnt;
    int               tests_run;
    int               tests_failed;
    logic [LED_W-1:0] model_leds;               // reference led register
    logic [7:0]       exp_bytes[$];             // echoes still owed in order
    logic [LED_W-1:0] exp_leds[$];              // led state after each of them

    led_top #(
        .CLKS_PER_BIT(BIT_CLKS),
        .FIFO_DEPTH  (8),
        .LOCK_COUNT  (LOCK_CNT)
    ) u_led_top (
        .pll_clk     (pll_clk),
        .rst_i       (rst_i),
        .pll_locked_i(pll_locked_i),
        .uart_rx_i   (uart_rx_i),
        .leds_o      (leds_o),
        .uart_tx_o   (uart_tx_o)
    );

    initial begin
        pll_clk = 1'b0;
        forever #10 pll_clk = ~pll_clk;         // 20 ns period
    end

    // watchdog sized from the frame count
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge pll_clk);
            cycle_cnt++;
        end
        $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    function automatic logic [LED_W-1:0] apply_cmd(input logic [LED_W-1:0] leds,
                                                   input logic [7:0] b);
        cmd_byte_u        c;
        logic [LED_W-1:0] nxt;
        c.raw = b;
        nxt   = leds;
        case (c.fields.op)
            OP_SET_LO: nxt[3:0] = c.fields.arg[3:0];
            OP_SET_HI: nxt[7:4] = c.fields.arg[3:0];
            OP_TOGGLE: nxt[5:0] = leds[5:0] ^ c.fields.arg;
            default:   nxt      = '0;           // clear
        endcase
        return nxt;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [7:0] exp, input logic [7:0] act);
        check_cnt++;
        assert (act === exp) else begin
            $display("** Error [%s] %s: expected %02h, actual %02h", test, what, exp, act);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////
    // serial driver and line monitor
    ////////////////////////////////////////
    task automatic drive_bit(input logic v);
        @(posedge pll_clk);
        #2;
        uart_rx_i = v;
        repeat (BIT_CLKS - 1) @(posedge pll_clk);
    endtask

    task automatic send_frame(input logic [7:0] b, input int gap);
        model_leds = apply_cmd(model_leds, b);
        exp_bytes.push_back(b);
        exp_leds.push_back(model_leds);
        drive_bit(1'b0);                        // start
        for (int i = 0; i < 8; i++) drive_bit(b[i]);
        drive_bit(1'b1);                        // stop
        repeat (gap) drive_bit(1'b1);           // idle bits
    endtask

    // deserialize one echo at mid-bit and take the leds mid stop bit
    task automatic receive_echo(output logic [7:0] data, output logic [7:0] leds_seen,
                                output logic stop_bit, output bit found);
        int waited;
        waited = 0;
        data   = '0;
        @(negedge pll_clk);
        while (uart_tx_o !== 1'b0 && waited < ECHO_WAIT) begin
            @(negedge pll_clk);
            waited++;
        end
        found = (uart_tx_o === 1'b0);
        if (found) begin
            repeat (BIT_CLKS / 2) @(negedge pll_clk);   // middle of start bit
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge pll_clk);
                data[i] = uart_tx_o;
            end
            repeat (BIT_CLKS) @(negedge pll_clk);
            stop_bit  = uart_tx_o;
            leds_seen = leds_o;
        end
    endtask

    // wait for an echo start bit without reading the frame
    task automatic wait_echo_start(input string test);
        int waited;
        waited = 0;
        @(negedge pll_clk);
        while (uart_tx_o !== 1'b0 && waited < ECHO_WAIT) begin
            @(negedge pll_clk);
            waited++;
        end
        if (uart_tx_o !== 1'b0) begin
            $display("[%s] echo start bit never appeared on uart_tx_o", test);
            err_cnt++;
        end
    endtask

    task automatic collect_echoes(input string test, input int n);
        logic [7:0] got;
        logic [7:0] leds_seen;
        logic       stop_bit;
        bit         found;
        for (int i = 0; i < n; i++) begin
            receive_echo(got, leds_seen, stop_bit, found);
            if (!found) begin
                $display("[%s] echo %0d of %0d never appeared on uart_tx_o", test, i + 1, n);
                err_cnt++;
                break;
            end
            check_value(test, "echo byte", exp_bytes.pop_front(), got);
            check_value(test, "leds", exp_leds.pop_front(), leds_seen);
            check_value(test, "stop bit", 8'h01, {7'b0, stop_bit});
        end
    endtask

    // random frames with no idle gap between them in a burst
    task automatic run_frames(input string test, input int n, input bit burst);
        logic [7:0] b;
        int         gap;
        exp_bytes.delete();
        exp_leds.delete();
        fork
            for (int i = 0; i < n; i++) begin
                b   = $random(seed);
                gap = burst ? 0 : ($random(seed) & 3);
                send_frame(b, gap);
            end
            collect_echoes(test, n);
        join
    endtask

    task automatic report_test(input string test, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %-10s ok", test);
        end else begin
            tests_failed++;
            $display("test %-10s FAILED, %0d errors", test, err_cnt - errs_before);
        end
    endtask

    // idle line and cleared leds over a window of cycles
    task automatic check_quiet(input string test, input int cycles);
        repeat (cycles) begin
            @(negedge pll_clk);
            check_value(test, "leds held in reset", 8'h00, leds_o);
            check_value(test, "tx line held idle", 8'h01, {7'b0, uart_tx_o});
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        int errs;
        rst_i        = 1'b1;
        pll_locked_i = 1'b0;
        uart_rx_i    = 1'b1;
        seed         = 32'hf388584c;
        err_cnt      = 0;
        check_cnt    = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_leds   = '0;

        repeat (3) @(posedge pll_clk);
        #2 rst_i = 1'b0;
        @(posedge pll_clk);
        #2 pll_locked_i = 1'b1;
        repeat (LOCK_CNT + 8) @(posedge pll_clk);   // sync + lock count + margin

        errs = err_cnt;
        run_frames("echo_cmds", 40, 1'b0);
        report_test("echo_cmds", errs);

        errs = err_cnt;
        run_frames("burst", 8, 1'b1);
        report_test("burst", errs);

        // lock drop while an echo is on the line
        errs = err_cnt;
        send_frame(8'h4a, 0);                   // set high nibble to a
        wait_echo_start("lock_loss");
        @(posedge pll_clk);
        #2 pll_locked_i = 1'b0;
        repeat (4) @(posedge pll_clk);          // synchronizer before the core reset
        check_quiet("lock_loss", 20);
        @(posedge pll_clk);
        #2 pll_locked_i = 1'b1;
        repeat (LOCK_CNT + 6) @(posedge pll_clk);
        model_leds = '0;
        run_frames("lock_loss", 1, 1'b0);
        report_test("lock_loss", errs);

        // external reset with nonzero leds and an echo under way
        errs = err_cnt;
        send_frame(8'h4a, 0);                   // set high nibble to a
        wait_echo_start("ext_reset");
        @(posedge pll_clk);
        #2 rst_i = 1'b1;
        repeat (3) @(posedge pll_clk);
        check_quiet("ext_reset", 1);
        @(posedge pll_clk);
        #2 rst_i = 1'b0;
        repeat (LOCK_CNT + 6) @(posedge pll_clk);
        model_leds = '0;
        run_frames("ext_reset", 6, 1'b0);
        report_test("ext_reset", errs);

        err_cnt += u_led_top.u_led_top_properties.fail_cnt;    // bound assertion failures
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/led_top_properties.sv
`timescale 1ns/1ps

module led_top_properties (
    input logic       pll_clk,
    input logic       core_rst_i,
    input logic       tx_line_i,                // uart_tx_o of the top level
    input logic [7:0] leds_i,
    input logic       fifo_wr_i,
    input logic       fifo_empty_i,
    input logic       tx_start_i,
    input logic       tx_busy_i
);

    int fail_cnt = 0;                           // failed assertions so far

    ////////////////////////////////////////
    // reset state after one edge to let the sync reset land
    ////////////////////////////////////////
    a_quiet_in_reset: assert property (@(posedge pll_clk)
        core_rst_i [*2] |-> (tx_line_i && leds_i == '0))
        else begin
            $error("line not idle or leds not cleared while core reset is held");
            fail_cnt++;
        end

    // a written byte is at the fifo head one cycle later
    a_wr_visible: assert property (@(posedge pll_clk) disable iff (core_rst_i)
        fifo_wr_i |=> !fifo_empty_i)
        else begin
            $error("fifo still empty the cycle after a write");
            fail_cnt++;
        end

    // guard flag in the executor keeps starts apart
    a_start_not_busy: assert property (@(posedge pll_clk) disable iff (core_rst_i)
        tx_start_i |-> !tx_busy_i)
        else begin
            $error("tx_start raised while transmitter busy");
            fail_cnt++;
        end

endmodule

bind led_top led_top_properties u_led_top_properties (
    .pll_clk     (pll_clk),
    .core_rst_i  (core_rst),
    .tx_line_i   (uart_tx_o),
    .leds_i      (leds_o),
    .fifo_wr_i   (rx_valid),
    .fifo_empty_i(fifo_empty),
    .tx_start_i  (tx_start),
    .tx_busy_i   (tx_busy)
);

//--- rtl/led_top.sv
`timescale 1ns/1ps

module led_top
    import cmd_pkg::*;
#(
    parameter int CLKS_PER_BIT = 104,
    parameter int FIFO_DEPTH   = 8,
    parameter int LOCK_COUNT   = 15
) (
    input  logic             pll_clk,
    input  logic             rst_i,
    input  logic             pll_locked_i,      // async from the pll
    input  logic             uart_rx_i,
    output logic [LED_W-1:0] leds_o,
    output logic             uart_tx_o
);

    logic       core_rst;                       // reset for everything below
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic [7:0] fifo_data;
    logic       fifo_empty;
    logic       fifo_pop;
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;

    ////////////////////////////////////////
    // reset, then rx -> fifo -> exec -> tx
    ////////////////////////////////////////
    reset_ctrl #(.LOCK_COUNT(LOCK_COUNT)) u_reset_ctrl (
        .pll_clk     (pll_clk),
        .rst_i       (rst_i),
        .pll_locked_i(pll_locked_i),
        .core_rst_o  (core_rst)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .pll_clk(pll_clk),
        .rst_i  (core_rst),
        .rx_i   (uart_rx_i),
        .byte_o (rx_byte),
        .valid_o(rx_valid)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_byte_fifo (
        .pll_clk  (pll_clk),
        .rst_i    (core_rst),
        .wr_i     (rx_valid),
        .wr_data_i(rx_byte),
        .pop_i    (fifo_pop),
        .rd_data_o(fifo_data),
        .empty_o  (fifo_empty)
    );

    cmd_exec u_cmd_exec (
        .pll_clk     (pll_clk),
        .rst_i       (core_rst),
        .fifo_data_i (fifo_data),
        .fifo_empty_i(fifo_empty),
        .tx_busy_i   (tx_busy),
        .fifo_pop_o  (fifo_pop),
        .tx_start_o  (tx_start),
        .tx_byte_o   (tx_byte),
        .leds_o      (leds_o)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .pll_clk(pll_clk),
        .rst_i  (core_rst),
        .start_i(tx_start),
        .byte_i (tx_byte),
        .tx_o   (uart_tx_o),
        .busy_o (tx_busy)
    );

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import serial_pkg::*;
#(
    parameter int CLKS_PER_BIT = 104            // pll_clk cycles per serial bit
) (
    input  logic                  pll_clk,
    input  logic                  rst_i,
    input  logic                  start_i,      // one cycle, ignored while busy
    input  logic [FRAME_BITS-1:0] byte_i,
    output logic                  tx_o,         // serial line, idles high
    output logic                  busy_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(FRAME_BITS);

    bit_phase_e            state;
    logic [CNT_W-1:0]      clk_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic                  bit_tick;            // last cycle of current bit
    logic                  go;
    logic [FRAME_BITS-1:0] shreg;               // bit 0 is on the line during DATA

    assign bit_tick = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign go       = (state == IDLE) && start_i;
    assign busy_o   = (state != IDLE);          // rises the cycle after start_i

    ////////////////////////////////////////
    // line and phase control
    ////////////////////////////////////////
    always_ff @(posedge pll_clk) begin
        if (rst_i) begin
            state   <= IDLE;
            tx_o    <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            clk_cnt <= bit_tick ? '0 : clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (start_i) begin
                        state <= START;
                        tx_o  <= 1'b0;          // start bit
                    end
                end
                START: if (bit_tick) begin
                    state   <= DATA;
                    bit_cnt <= '0;
                    tx_o    <= shreg[0];
                end
                DATA: if (bit_tick) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                        state <= STOP;
                        tx_o  <= 1'b1;          // stop bit
                    end else begin
                        tx_o  <= shreg[1];      // shreg moves on this edge too
                    end
                end
                STOP: if (bit_tick) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // payload
    always_ff @(posedge pll_clk) begin
        if (go) begin
            shreg <= byte_i;
        end else if (state == DATA && bit_tick) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

//--- rtl/cmd_exec.sv
`timescale 1ns/1ps

module cmd_exec
    import cmd_pkg::*;
(
    input  logic             pll_clk,
    input  logic             rst_i,
    input  logic [7:0]       fifo_data_i,       // fifo head
    input  logic             fifo_empty_i,
    input  logic             tx_busy_i,
    output logic             fifo_pop_o,        // one cycle per byte taken
    output logic             tx_start_o,        // kicks the echo
    output logic [7:0]       tx_byte_o,
    output logic [LED_W-1:0] leds_o
);

    cmd_byte_u cmd;                             // head, both views
    logic      wait_busy;                       // popped, tx has not gone busy yet

    assign cmd.raw = fifo_data_i;

    // take a byte only if the echo of the previous one can start
    always_comb begin
        fifo_pop_o = ~fifo_empty_i & ~tx_busy_i & ~wait_busy;
    end

    ////////////////////////////////////////
    // handshake to the transmitter
    ////////////////////////////////////////
    always_ff @(posedge pll_clk) begin
        if (rst_i) begin
            tx_start_o <= 1'b0;
            wait_busy  <= 1'b0;
        end else begin
            tx_start_o <= fifo_pop_o;           // one cycle after the pop
            if (tx_busy_i) begin
                wait_busy <= 1'b0;              // busy now blocks pops itself
            end else if (fifo_pop_o) begin
                wait_busy <= 1'b1;              // covers the tx_start cycle
            end
        end
    end

    // echo payload, raw character view
    always_ff @(posedge pll_clk) begin
        if (fifo_pop_o) tx_byte_o <= cmd.raw;
    end

    ////////////////////////////////////////
    // led commands, field view
    ////////////////////////////////////////
    always_ff @(posedge pll_clk) begin
        if (rst_i) begin
            leds_o <= '0;
        end else if (fifo_pop_o) begin          // same edge that raises tx_start
            case (cmd.fields.op)
                OP_SET_LO: leds_o[3:0] <= cmd.fields.arg[3:0];
                OP_SET_HI: leds_o[7:4] <= cmd.fields.arg[3:0];
                OP_TOGGLE: leds_o[5:0] <= leds_o[5:0] ^ cmd.fields.arg;
                OP_CLEAR:  leds_o      <= '0;
                default:   leds_o      <= leds_o;
            endcase
        end
    end

endmodule

//--- rtl/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo #(
    parameter int FIFO_DEPTH = 8                // entries, power of two
) (
    input  logic       pll_clk,
    input  logic       rst_i,
    input  logic       wr_i,                    // write strobe
    input  logic [7:0] wr_data_i,
    input  logic       pop_i,                   // advance head on next edge
    output logic [7:0] rd_data_o,               // head, first word fall through
    output logic       empty_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [7:0]  mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;                        // extra msb tells full from empty
    logic [AW:0] rd_ptr;
    logic        full;
    logic        do_wr;
    logic        do_rd;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_wr = wr_i & ~full;                // full fifo drops the byte
    assign do_rd = pop_i & ~empty_o;

    ////////////////////////////////////////
    // pointers
    ////////////////////////////////////////
    always_ff @(posedge pll_clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // storage
    always_ff @(posedge pll_clk) begin
        if (do_wr) mem[wr_ptr[AW-1:0]] <= wr_data_i;
    end

    assign rd_data_o = mem[rd_ptr[AW-1:0]];     // head is always visible

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import serial_pkg::*;
#(
    parameter int CLKS_PER_BIT = 104            // pll_clk cycles per serial bit
) (
    input  logic                  pll_clk,
    input  logic                  rst_i,
    input  logic                  rx_i,         // serial line, idles high
    output logic [FRAME_BITS-1:0] byte_o,       // last complete byte
    output logic                  valid_o       // one cycle, mid stop bit
);

    localparam int CNT_W    = $clog2(CLKS_PER_BIT);
    localparam int BIT_W    = $clog2(FRAME_BITS);
    localparam int HALF_BIT = CLKS_PER_BIT / 2;

    logic                  rx_meta;
    logic                  rx_sync;             // line after two flops
    bit_phase_e            state;
    logic [CNT_W-1:0]      clk_cnt;             // cycles inside current bit
    logic [BIT_W-1:0]      bit_cnt;             // data bit index
    logic                  bit_tick;            // at the sample point of a bit
    logic                  half_tick;           // middle of the start bit
    logic [FRAME_BITS-1:0] shreg;               // data bits shift in from the top

    assign bit_tick  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign half_tick = (clk_cnt == CNT_W'(HALF_BIT - 1));

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////
    always_ff @(posedge pll_clk) begin
        if (rst_i) begin
            rx_meta <= 1'b1;                    // treat line as idle
            rx_sync <= 1'b1;
            state   <= IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            valid_o <= 1'b0;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            valid_o <= 1'b0;                    // strobe by default low
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= START;       // falling start edge
                end
                START: begin
                    if (half_tick) begin
                        clk_cnt <= '0;          // from here on sample at mid-bit
                        bit_cnt <= '0;
                        // a short glitch is not a start bit
                        state   <= rx_sync ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(FRAME_BITS - 1)) state <= STOP;
                    end
                end
                STOP: begin
                    if (bit_tick) begin
                        valid_o <= rx_sync;     // framing error -> byte dropped
                        state   <= IDLE;        // ready for a back-to-back start
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload, lsb arrives first
    always_ff @(posedge pll_clk) begin
        if (state == DATA && bit_tick) shreg <= {rx_sync, shreg[FRAME_BITS-1:1]};
    end

    assign byte_o = shreg;                      // stable until next frame's data

endmodule

//--- rtl/reset_ctrl.sv
`timescale 1ns/1ps

module reset_ctrl #(
    parameter int LOCK_COUNT = 15               // locked cycles needed before release
) (
    input  logic pll_clk,
    input  logic rst_i,
    input  logic pll_locked_i,                  // async straight from the pll
    output logic core_rst_o
);

    localparam int CNT_W = $clog2(LOCK_COUNT + 1);

    logic             lock_meta;                // first synchronizer stage
    logic             lock_sync;                // safe to use in pll_clk domain
    logic [CNT_W-1:0] lock_cnt;                 // consecutive locked cycles
    logic             lock_done;

    // two flops for the async lock
    always_ff @(posedge pll_clk) begin
        lock_meta <= pll_locked_i;
        lock_sync <= lock_meta;
    end

    assign lock_done = (lock_cnt == CNT_W'(LOCK_COUNT));

    // any unlocked cycle starts the wait over
    always_ff @(posedge pll_clk) begin
        if (rst_i || !lock_sync) begin
            lock_cnt <= '0;
        end else if (!lock_done) begin
            lock_cnt <= lock_cnt + 1'b1;        // saturates at LOCK_COUNT
        end
    end

    // held while the external reset is up, the lock is gone,
    // or the lock has not yet been stable long enough
    assign core_rst_o = rst_i | ~lock_sync | ~lock_done;

endmodule

//--- rtl/serial_pkg.sv
package serial_pkg;

    localparam int FRAME_BITS = 8;              // data bits per frame, no parity

    ////////////////////////////////////////
    // bit phase of a frame, same walk for rx and tx
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        IDLE  = 2'd0,                           // line high, nothing going on
        START = 2'd1,                           // start bit (low)
        DATA  = 2'd2,                           // eight data bits, lsb first
        STOP  = 2'd3                            // stop bit (high)
    } bit_phase_e;

endpackage

//--- rtl/cmd_pkg.sv
package cmd_pkg;

    localparam int LED_W = 8;                   // width of the board led port

    ////////////////////////////////////////
    // opcode in the two top bits of a command byte
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        OP_SET_LO = 2'd0,                       // leds[3:0] <= arg[3:0]
        OP_SET_HI = 2'd1,                       // leds[7:4] <= arg[3:0]
        OP_TOGGLE = 2'd2,                       // leds[5:0] ^= arg
        OP_CLEAR  = 2'd3                        // all leds off
    } cmd_op_e;

    typedef struct packed {
        cmd_op_e    op;                         // bits 7..6
        logic [5:0] arg;                        // bits 5..0
    } cmd_fields_s;

    // one received byte, read as a plain char for the echo
    // and as opcode plus argument for the led logic
    typedef union packed {
        logic [7:0]  raw;
        cmd_fields_s fields;
    } cmd_byte_u;

endpackage
